// ==== rtl/usiBusPkg.sv ====
// Bus protocol package
// Data, CSR address and block number widths
// Command code enum and address word layout
// Command and response structs carried on the bus
`default_nettype none

package usiBusPkg;

	//------------------------------------------------------------
	// Plain widths
	//------------------------------------------------------------
	typedef logic [31:0] usiData;       // Bus data word
	typedef logic [15:0] usiCsrAdrs;    // CSR address inside a block
	typedef logic [7:0]  usiBlock;      // Block number
	typedef logic [31:0] usiAdrs;       // Raw address word

	// Command code in address bits 31:30
	typedef enum logic [1:0]
	{
		CmdNone  = 2'd0,                // No operation
		CmdWrite = 2'd1,
		CmdRead  = 2'd2,
		CmdWrRd  = 2'd3                 // Not implemented, ignored by slaves
	} usiCmd;

	// Named view of the address word
	typedef struct packed
	{
		usiCmd     cmd;                 // 31:30
		logic [5:0] rsvd;               // 29:24 reserved
		usiBlock   block;               // 23:16
		usiCsrAdrs csr;                 // 15:0
	} usiAdrsFields;

	//------------------------------------------------------------
	// Bus transport structs
	//------------------------------------------------------------
	typedef struct packed
	{
		usiData       wd;               // Write data
		usiAdrsFields adrs;             // Command, block, CSR
		logic         stb;              // Command valid qualifier
	} usiCmdBus;                        // 65 bits

	typedef struct packed
	{
		usiData data;                   // Read data
		logic   valid;                  // One-cycle read valid
	} usiSlvRsp;                        // 33 bits

endpackage

`default_nettype wire

// ==== rtl/usiMapPkg.sv ====
// Address map package
// Block numbers, slave count and slave index positions
// Block to slave index lookup, unmapped marker word
`default_nettype none

package usiMapPkg;
	import usiBusPkg::*;

	localparam usiBlock GpioBlock = 8'd1;
	localparam usiBlock RamBlock  = 8'd2;
	localparam int      SlaveCnt  = 2;

	typedef logic [$clog2(SlaveCnt)-1:0] usiSlvIdx;

	localparam usiSlvIdx GpioIdx = 1'd0;   // Response slot of GPIO
	localparam usiSlvIdx RamIdx  = 1'd1;   // Response slot of RAM

	// Returned for unmapped blocks, easy to spot in a trace
	localparam usiData UnmappedWord = 32'h1234_5678;

	typedef struct packed
	{
		logic     hit;                  // Block is mapped
		usiSlvIdx idx;                  // Slave slot
	} usiSlvSel;

	// Block number to slave slot
	function automatic usiSlvSel mapBlock(input usiBlock blk);
		usiSlvSel sel;
		sel = '0;
		case (blk)
			GpioBlock:
			begin
				sel.hit = 1'b1;
				sel.idx = GpioIdx;
			end
			RamBlock:
			begin
				sel.hit = 1'b1;
				sel.idx = RamIdx;
			end
			default: sel = '0;          // Miss
		endcase
		return sel;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/usiBus.sv ====
// Bus stage between one master and the slaves
// Command register broadcast to all slaves
// Delayed block field and read flag aligned with slave data
// Registered read return mux with unmapped marker
`default_nettype none
`timescale 1ns/10ps

module usiBus
(
	input  wire logic                                iUsiClk,
	input  wire logic                                rst,
	input  wire usiBusPkg::usiCmdBus                 cmdIn,     // From master
	output      usiBusPkg::usiCmdBus                 slvCmd,    // To every slave
	input  wire usiBusPkg::usiSlvRsp [usiMapPkg::SlaveCnt-1:0] slvRsp,
	output      usiBusPkg::usiData                   rdData,
	output      logic [usiMapPkg::SlaveCnt-1:0]      rdValid    // One bit per slave
);
	import usiBusPkg::*;
	import usiMapPkg::*;

	usiBlock                blkDly;     // Block field, one stage behind slvCmd
	logic                   rdDly;      // Read was broadcast last cycle
	usiSlvSel               sel;        // Return source
	logic [SlaveCnt-1:0]    rspVld;     // Gathered valid bits

	//------------------------------------------------------------
	// Command stage, master to slaves
	//------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			slvCmd <= '0;
		else
			slvCmd <= cmdIn;            // Edge 0, slaves see it in cycle 1
	end

	// Track the broadcast command so the return mux lines up with slave data
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			blkDly <= '0;
			rdDly  <= 1'b0;
		end
		else
		begin
			blkDly <= slvCmd.adrs.block;
			rdDly  <= slvCmd.stb && (slvCmd.adrs.cmd == CmdRead);
		end
	end

	//------------------------------------------------------------
	// Return stage, slaves to master
	//------------------------------------------------------------
	assign sel = mapBlock(blkDly);

	always_comb
	begin
		for (int i = 0; i < SlaveCnt; i++)
			rspVld[i] = slvRsp[i].valid;
	end

	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			rdData  <= '0;
			rdValid <= '0;
		end
		else
		begin
			rdValid <= rspVld;          // Edge 2
			if (rdDly)                  // Hold last value when idle
			begin
				if (sel.hit)
					rdData <= slvRsp[sel.idx].data;
				else
					rdData <= UnmappedWord;   // Decode miss marker
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/usiGpioCsr.sv ====
// GPIO slave on the register bus
// CSR 0 output register, written and read back
// CSR 1 input pins through a two-flop synchronizer
// Other CSRs read zero
`default_nettype none
`timescale 1ns/10ps

module usiGpioCsr #(
	parameter int pGpioW = 16           // Pin count, at most 32
)(
	input  wire logic                iUsiClk,
	input  wire logic                rst,
	input  wire usiBusPkg::usiCmdBus slvCmd,
	output      usiBusPkg::usiSlvRsp slvRsp,
	input  wire logic [pGpioW-1:0]   gpioIn,
	output      logic [pGpioW-1:0]   gpioOut
);
	import usiBusPkg::*;
	import usiMapPkg::*;

	localparam usiCsrAdrs CsrOut = 16'h0000;
	localparam usiCsrAdrs CsrIn  = 16'h0001;

	logic              hit;             // Strobed command for this block
	logic [pGpioW-1:0] syncQ1;          // First sync flop
	logic [pGpioW-1:0] syncQ2;          // Stable pin value
	logic              rdVld;
	usiData            rdWord;

	assign hit = slvCmd.stb && (slvCmd.adrs.block == GpioBlock);

	//------------------------------------------------------------
	// Output register and pin synchronizer
	//------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			gpioOut <= '0;
			syncQ1  <= '0;
			syncQ2  <= '0;
		end
		else
		begin
			syncQ1 <= gpioIn;
			syncQ2 <= syncQ1;
			if (hit && (slvCmd.adrs.cmd == CmdWrite) && (slvCmd.adrs.csr == CsrOut))
				gpioOut <= slvCmd.wd[pGpioW-1:0];   // Edge 1
		end
	end

	//------------------------------------------------------------
	// CSR readback
	//------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			rdVld <= 1'b0;
		else
			rdVld <= hit && (slvCmd.adrs.cmd == CmdRead);   // Single cycle pulse
	end

	always_ff @(posedge iUsiClk)
	begin
		if (hit && (slvCmd.adrs.cmd == CmdRead))
		begin
			case (slvCmd.adrs.csr)
				CsrOut:  rdWord <= usiData'(gpioOut);   // Zero-extended
				CsrIn:   rdWord <= usiData'(syncQ2);
				default: rdWord <= '0;
			endcase
		end
	end

	assign slvRsp = '{data: rdWord, valid: rdVld};

endmodule

`default_nettype wire

// ==== rtl/usiRamCsr.sv ====
// RAM slave on the register bus
// pRamDepth words of 32 bits at CSR 0 upward
// Synchronous write and read, out of range reads zero
`default_nettype none
`timescale 1ns/10ps

module usiRamCsr #(
	parameter int pRamDepth = 64        // Power of two
)(
	input  wire logic                iUsiClk,
	input  wire logic                rst,
	input  wire usiBusPkg::usiCmdBus slvCmd,
	output      usiBusPkg::usiSlvRsp slvRsp
);
	import usiBusPkg::*;
	import usiMapPkg::*;

	localparam int AdrsW = $clog2(pRamDepth);

	usiData           mem [pRamDepth];  // Word storage
	logic             hit;
	logic             inRange;          // CSR below depth
	logic [AdrsW-1:0] wordIdx;
	logic             rdVld;
	usiData           rdWord;

	assign hit     = slvCmd.stb && (slvCmd.adrs.block == RamBlock);
	assign inRange = 32'(slvCmd.adrs.csr) < pRamDepth;
	assign wordIdx = slvCmd.adrs.csr[AdrsW-1:0];

	//------------------------------------------------------------
	// Memory port
	//------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (hit && inRange && (slvCmd.adrs.cmd == CmdWrite))
			mem[wordIdx] <= slvCmd.wd;          // Edge 1
		if (hit && (slvCmd.adrs.cmd == CmdRead))
			rdWord <= inRange ? mem[wordIdx] : '0;   // Above depth reads zero
	end

	// Read valid, only control state here
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			rdVld <= 1'b0;
		else
			rdVld <= hit && (slvCmd.adrs.cmd == CmdRead);
	end

	assign slvRsp = '{data: rdWord, valid: rdVld};

endmodule

`default_nettype wire

// ==== rtl/usiSubsysTop.sv ====
// Register bus subsystem top level
// Bus stage, GPIO slave and RAM slave
// Responses placed at the slots from the address map
`default_nettype none
`timescale 1ns/10ps

module usiSubsysTop #(
	parameter int pRamDepth = 64,       // RAM word count
	parameter int pGpioW    = 16        // GPIO pin count
)(
	input  wire logic                           iUsiClk,
	input  wire logic                           rst,
	input  wire usiBusPkg::usiCmdBus            cmdIn,
	output      usiBusPkg::usiData              rdData,
	output      logic [usiMapPkg::SlaveCnt-1:0] rdValid,
	input  wire logic [pGpioW-1:0]              gpioIn,
	output      logic [pGpioW-1:0]              gpioOut
);
	import usiBusPkg::*;
	import usiMapPkg::*;

	usiCmdBus                   slvCmd; // Broadcast command
	usiSlvRsp [SlaveCnt-1:0]    slvRsp; // Indexed by map slot

	//------------------------------------------------------------
	// Bus stage
	//------------------------------------------------------------
	usiBus u_usiBus (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.cmdIn   (cmdIn),
		.slvCmd  (slvCmd),
		.slvRsp  (slvRsp),
		.rdData  (rdData),
		.rdValid (rdValid)
	);

	//------------------------------------------------------------
	// Slaves
	//------------------------------------------------------------
	usiGpioCsr #(.pGpioW(pGpioW)) u_usiGpioCsr (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.slvCmd  (slvCmd),
		.slvRsp  (slvRsp[GpioIdx]),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut)
	);

	usiRamCsr #(.pRamDepth(pRamDepth)) u_usiRamCsr (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.slvCmd  (slvCmd),
		.slvRsp  (slvRsp[RamIdx])
	);

endmodule

`default_nettype wire

// ==== dv/usiSubsysTb.sv ====
// Testbench for the register bus subsystem
// Clock, reset, command tasks and GPIO and RAM models
// Read scoreboard checked by assertions at the read return
// Per-test report lines, closing counts and watchdog
`default_nettype none
`timescale 1ns/10ps

module usiSubsysTb;
	import usiBusPkg::*;
	import usiMapPkg::*;

	localparam int Period     = 40;
	localparam int RamDepth   = 64;
	localparam int GpioW      = 16;
	// Cycle budget of each test from reset state to ignored commands
	localparam int TestCycles = 8 + 30 + 50 + 20 + 10 + 25;
	localparam int WatchdogNs = (TestCycles + 40) * Period;

	logic                iUsiClk;
	logic                rst;
	usiCmdBus            cmdIn;
	usiData              rdData;
	logic [SlaveCnt-1:0] rdValid;
	logic [GpioW-1:0]    gpioIn;
	logic [GpioW-1:0]    gpioOut;

	usiData              ramModel [int];    // Written RAM words only
	logic [GpioW-1:0]    gpioModel;         // Output register as issued
	logic [GpioW-1:0]    gpioD1;
	logic [GpioW-1:0]    gpioD2;            // Aligned with the slave write
	logic [2:0]          rdPipe;            // Read strobe age in edges
	usiData              expData [$];       // Scoreboard in issue order
	logic [SlaveCnt-1:0] expVld [$];
	usiData              eData;
	logic [SlaveCnt-1:0] eVld;
	usiData              lastData;          // Last read data returned
	int                  errCnt;
	int                  errAtStart;
	int                  testCnt;
	int                  badTests;

	usiSubsysTop #(.pRamDepth(RamDepth), .pGpioW(GpioW)) u_usiSubsysTop (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.cmdIn   (cmdIn),
		.rdData  (rdData),
		.rdValid (rdValid),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut)
	);

	always #(Period / 2) iUsiClk = ~iUsiClk;

	//------------------------------------------------------------
	// Models and checks
	//------------------------------------------------------------
	function automatic logic [SlaveCnt-1:0] slotBits(input usiBlock blk);
		logic [SlaveCnt-1:0] v;
		v = '0;
		if (blk == GpioBlock)
			v[GpioIdx] = 1'b1;
		else if (blk == RamBlock)
			v[RamIdx] = 1'b1;
		return v;                       // Zero for unmapped blocks
	endfunction

	function automatic void predictWrite(input usiBlock blk, input usiCsrAdrs csr,
		input usiData wd);
		if (blk == GpioBlock && csr == 16'h0)
			gpioModel = wd[GpioW-1:0];
		else if (blk == RamBlock && 32'(csr) < RamDepth)
			ramModel[int'(csr)] = wd;
	endfunction

	function automatic void predictRead(input usiBlock blk, input usiCsrAdrs csr);
		usiData d;
		if (blk == GpioBlock)
			d = (csr == 16'h0) ? usiData'(gpioModel) : (csr == 16'h1) ? usiData'(gpioIn) : '0;
		else if (blk == RamBlock)
			d = (32'(csr) < RamDepth) ? ramModel[int'(csr)] : '0;
		else
			d = UnmappedWord;           // Decode miss
		expData.push_back(d);
		expVld.push_back(slotBits(blk));
	endfunction

	function automatic void reportMismatch(input string sig, input usiData exp,
		input usiData act);
		errCnt++;
		$display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
	endfunction

	// Read strobe ages and GPIO model delayed to the slave write
	always @(posedge iUsiClk)
	begin
		if (rst)
		begin
			rdPipe <= '0;
			gpioD1 <= '0;
			gpioD2 <= '0;
		end
		else
		begin
			rdPipe <= {rdPipe[1:0], cmdIn.stb && (cmdIn.adrs.cmd == CmdRead)};
			gpioD1 <= gpioModel;
			gpioD2 <= gpioD1;
		end
	end

	always @(negedge iUsiClk)
	begin
		if (!rst)
		begin
			assert (gpioOut == gpioD2)
				else reportMismatch("gpioOut", usiData'(gpioD2), usiData'(gpioOut));
			if (rdPipe[2])              // Three edges after the strobe
			begin
				if (expData.size() == 0)
				begin
					errCnt++;
					$display("Read returned at %0t with no read on record", $time);
				end
				else
				begin
					eData    = expData.pop_front();
					eVld     = expVld.pop_front();
					lastData = eData;
					assert (rdValid == eVld)
						else reportMismatch("rdValid", usiData'(eVld), usiData'(rdValid));
					assert (rdData == eData) else reportMismatch("rdData", eData, rdData);
				end
			end
			else
			begin
				assert (rdValid == '0) else reportMismatch("rdValid", '0, usiData'(rdValid));
				// Idle return cycle holds the last read data
				assert (rdData == lastData) else reportMismatch("rdData", lastData, rdData);
			end
		end
	end

	//------------------------------------------------------------
	// Stimulus tasks started just after a rising edge
	//------------------------------------------------------------
	task automatic sendCmd(input usiCmd cmd, input usiBlock blk, input usiCsrAdrs csr,
		input usiData wd, input logic stb);
		usiCmdBus c;
		c = '0;
		c.wd         = wd;
		c.adrs.cmd   = cmd;
		c.adrs.block = blk;
		c.adrs.csr   = csr;
		c.stb        = stb;
		cmdIn = c;
		if (stb && cmd == CmdWrite)
			predictWrite(blk, csr, wd);
		else if (stb && cmd == CmdRead)
			predictRead(blk, csr);
		@(posedge iUsiClk);
		#1;
	endtask

	task automatic idleCycles(input int n);
		cmdIn = '0;
		repeat (n) @(posedge iUsiClk);
		#1;
	endtask

	task automatic finishTest(input string name);
		idleCycles(4);                  // Return latency is three edges
		if (expData.size() != 0)
		begin
			errCnt++;
			$display("Test %s: %0d reads never returned", name, expData.size());
			expData.delete();
			expVld.delete();
		end
		testCnt++;
		if (errCnt == errAtStart)
			$display("Test %s ok", name);
		else
		begin
			badTests++;
			$display("Test %s failed with %0d errors", name, errCnt - errAtStart);
		end
		errAtStart = errCnt;
	endtask

	//------------------------------------------------------------
	// Tests
	//------------------------------------------------------------
	task automatic resetState();
		@(negedge iUsiClk);
		assert (rdValid == '0) else reportMismatch("rdValid", '0, usiData'(rdValid));
		assert (rdData == '0) else reportMismatch("rdData", '0, rdData);
		assert (gpioOut == '0) else reportMismatch("gpioOut", '0, usiData'(gpioOut));
		@(posedge iUsiClk);
		#1;
		finishTest("reset state");
	endtask

	task automatic gpioAccess();
		usiData r;
		r = $urandom;
		sendCmd(CmdWrite, GpioBlock, 16'h0, r, 1'b1);
		sendCmd(CmdRead, GpioBlock, 16'h0, '0, 1'b1);  // Upper bits read zero
		r = $urandom;
		gpioIn = r[GpioW-1:0];
		idleCycles(3);                  // Pins settle through the synchronizer
		sendCmd(CmdRead, GpioBlock, 16'h1, '0, 1'b1);
		sendCmd(CmdWrite, GpioBlock, 16'h1, $urandom, 1'b1);   // Input CSR ignores writes
		sendCmd(CmdRead, GpioBlock, 16'h0, '0, 1'b1);
		sendCmd(CmdRead, GpioBlock, 16'h5, '0, 1'b1);
		finishTest("gpio access");
	endtask

	task automatic ramBurst();
		int keys[$];
		int j;
		int t;
		repeat (12)
			sendCmd(CmdWrite, RamBlock, usiCsrAdrs'($urandom_range(RamDepth - 1, 0)),
				$urandom, 1'b1);
		foreach (ramModel[k])
			keys.push_back(k);
		for (int i = keys.size() - 1; i > 0; i--)
		begin
			j = int'($urandom_range(i, 0));
			t = keys[i];
			keys[i] = keys[j];
			keys[j] = t;
		end
		foreach (keys[i])               // One read per cycle
			sendCmd(CmdRead, RamBlock, usiCsrAdrs'(keys[i]), '0, 1'b1);
		finishTest("ram burst");
	endtask

	task automatic ramOutOfRange();
		sendCmd(CmdWrite, RamBlock, 16'h0, 32'hA5A5_0001, 1'b1);
		sendCmd(CmdRead, RamBlock, 16'(RamDepth), '0, 1'b1);
		sendCmd(CmdRead, RamBlock, 16'hFFFF, '0, 1'b1);
		sendCmd(CmdWrite, RamBlock, 16'(RamDepth), 32'hDEAD_BEEF, 1'b1);   // Would alias word 0
		sendCmd(CmdRead, RamBlock, 16'h0, '0, 1'b1);
		finishTest("ram out of range");
	endtask

	task automatic unmappedBlocks();
		sendCmd(CmdRead, 8'd0, 16'h0, '0, 1'b1);
		sendCmd(CmdRead, 8'd7, 16'h3, '0, 1'b1);
		finishTest("unmapped blocks");
	endtask

	task automatic ignoredCommands();
		sendCmd(CmdNone, GpioBlock, 16'h0, 32'h0000_BEEF, 1'b1);
		sendCmd(CmdWrRd, GpioBlock, 16'h0, 32'h0000_CAFE, 1'b1);
		sendCmd(CmdWrite, GpioBlock, 16'h0, 32'h0000_F00D, 1'b0);
		sendCmd(CmdNone, RamBlock, 16'h0, 32'h5555_6666, 1'b1);
		sendCmd(CmdWrRd, RamBlock, 16'h0, 32'h1111_2222, 1'b1);
		sendCmd(CmdWrite, RamBlock, 16'h0, 32'h3333_4444, 1'b0);
		sendCmd(CmdRead, RamBlock, 16'h0, '0, 1'b0);   // Strobe low so nothing returns
		sendCmd(CmdRead, GpioBlock, 16'h0, '0, 1'b1);
		sendCmd(CmdRead, RamBlock, 16'h0, '0, 1'b1);
		finishTest("ignored commands");
	endtask

	//------------------------------------------------------------
	// Run control
	//------------------------------------------------------------
	initial
	begin
		void'($urandom(32'ha727));
		iUsiClk    = 1'b0;
		rst        = 1'b1;
		cmdIn      = '0;
		gpioIn     = '0;
		gpioModel  = '0;
		lastData   = '0;
		errCnt     = 0;
		errAtStart = 0;
		testCnt    = 0;
		badTests   = 0;
		repeat (3) @(posedge iUsiClk);
		#1;
		rst = 1'b0;
		resetState();
		gpioAccess();
		ramBurst();
		ramOutOfRange();
		unmappedBlocks();
		ignoredCommands();
		$display("Tests %0d, failing %0d, errors %0d", testCnt, badTests, errCnt);
		if (errCnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(WatchdogNs);
		$display("Timeout: the tests ran past their time budget of %0d ns", WatchdogNs);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== usiSubsys.f ====
rtl/usiBusPkg.sv
rtl/usiMapPkg.sv
rtl/usiBus.sv
rtl/usiGpioCsr.sv
rtl/usiRamCsr.sv
rtl/usiSubsysTop.sv
dv/usiSubsysTb.sv

// ==== Makefile ====
# Verilator build and run of the register bus testbench

SIM  := obj_dir/VusiSubsysTb
SRCS := $(shell cat usiSubsys.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): usiSubsys.f $(SRCS)
	verilator --binary --timing --assert --top-module usiSubsysTb -f usiSubsys.f

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
